//--- Bender.yml
package:
  name: mdu

sources:
  - rv_pkg.sv
  - mdu_pkg.sv
  - iter_if.sv
  - mul_unit.sv
  - div_unit.sv
  - mdu_ctrl.sv
  - mdu_top.sv
  - target: test
    files:
      - tb_mdu.sv

//--- compile.f
rv_pkg.sv
mdu_pkg.sv
iter_if.sv
mul_unit.sv
div_unit.sv
mdu_ctrl.sv
mdu_top.sv
tb_mdu.sv

//--- div_unit.sv
`timescale 1ns/100ps

module div_unit (
    input  logic clk,
    input  logic reset_i,
    iter_if.unit bus
);

    logic                   busy_q;
    logic                   stop_q;
    mdu_pkg::cnt_t          cnt_q;
    logic                   neg_quot_q;
    logic                   neg_rem_q;
    logic                   zero_q;
    rv_pkg::word_t          dvd_q;
    rv_pkg::word_t          dvsr_q;
    rv_pkg::word_t          quot_q;
    rv_pkg::word_t          rem_q;
    rv_pkg::word_t          res_lo_q;
    rv_pkg::word_t          res_hi_q;

    logic                   sign1;
    logic                   sign2;
    rv_pkg::word_t          mag1;
    rv_pkg::word_t          mag2;
    logic [rv_pkg::XLEN:0]  rem_shift;
    logic [rv_pkg::XLEN:0]  diff;
    logic                   fits;
    rv_pkg::word_t          quot_next;
    rv_pkg::word_t          rem_next;
    logic                   last_step;

    assign sign1 = bus.op1_signed & bus.op1[rv_pkg::XLEN-1];
    assign sign2 = bus.op2_signed & bus.op2[rv_pkg::XLEN-1];
    assign mag1  = sign1 ? -bus.op1 : bus.op1;
    assign mag2  = sign2 ? -bus.op2 : bus.op2;

    // restoring step, bring in the next dividend bit and try a subtract
    assign rem_shift = {rem_q, quot_q[rv_pkg::XLEN-1]};
    assign diff      = rem_shift - {1'b0, dvsr_q};
    assign fits      = ~diff[rv_pkg::XLEN];
    assign rem_next  = fits ? diff[rv_pkg::XLEN-1:0] : rem_shift[rv_pkg::XLEN-1:0];
    assign quot_next = {quot_q[rv_pkg::XLEN-2:0], fits};
    assign last_step = busy_q && (cnt_q == mdu_pkg::cnt_t'(mdu_pkg::ITER_CYCLES - 1));

    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy_q <= 1'b0;
            stop_q <= 1'b0;
            cnt_q  <= '0;
        end else begin
            stop_q <= 1'b0;
            if (bus.cancel) begin
                busy_q <= 1'b0;
            end else if (bus.start) begin
                busy_q <= 1'b1;
                cnt_q  <= '0;
            end else if (busy_q) begin
                cnt_q <= cnt_q + 1'b1;
                if (last_step) begin
                    busy_q <= 1'b0;
                    stop_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus.start) begin
            quot_q     <= mag1;
            rem_q      <= '0;
            dvsr_q     <= mag2;
            dvd_q      <= bus.op1;
            zero_q     <= (bus.op2 == '0);
            neg_quot_q <= sign1 ^ sign2;
            neg_rem_q  <= sign1;
        end else if (busy_q && !bus.cancel) begin
            quot_q <= quot_next;
            rem_q  <= rem_next;
            if (last_step) begin
                // divide by zero returns all ones and the dividend untouched
                if (zero_q) begin
                    res_lo_q <= '1;
                    res_hi_q <= dvd_q;
                end else begin
                    // most negative by -1 lands on 2^31 rem 0, which is already the ISA result
                    res_lo_q <= neg_quot_q ? -quot_next : quot_next;
                    res_hi_q <= neg_rem_q ? -rem_next : rem_next;
                end
            end
        end
    end

    assign bus.stop   = stop_q;
    assign bus.res_lo = res_lo_q;
    assign bus.res_hi = res_hi_q;

    assert property (@(posedge clk) disable iff (reset_i)
        cnt_q <= mdu_pkg::ITER_CYCLES);

endmodule

//--- iter_if.sv
`timescale 1ns/100ps

interface iter_if;

    logic          start;
    logic          cancel;
    logic          op1_signed;
    logic          op2_signed;
    rv_pkg::word_t op1;
    rv_pkg::word_t op2;
    logic          stop;
    rv_pkg::word_t res_lo;
    rv_pkg::word_t res_hi;

    // controller side
    modport master (
        output start,
        output cancel,
        output op1_signed,
        output op2_signed,
        output op1,
        output op2,
        input  stop,
        input  res_lo,
        input  res_hi
    );

    // arithmetic unit side
    modport unit (
        input  start,
        input  cancel,
        input  op1_signed,
        input  op2_signed,
        input  op1,
        input  op2,
        output stop,
        output res_lo,
        output res_hi
    );

endinterface

//--- mdu_ctrl.sv
`timescale 1ns/100ps

module mdu_ctrl (
    input  logic            clk,
    input  logic            reset_i,
    input  logic            start_i,
    input  rv_pkg::mdu_op_e op_i,
    input  rv_pkg::word_t   op1_i,
    input  rv_pkg::word_t   op2_i,
    input  logic            cancel_i,
    output logic            busy_o,
    output logic            done_o,
    output rv_pkg::word_t   result_o,
    iter_if.master          mul_m,
    iter_if.master          div_m
);

    mdu_pkg::ctrl_state_e state_q;
    rv_pkg::mdu_op_e      op_q;
    rv_pkg::word_t        op1_q;
    rv_pkg::word_t        op2_q;
    logic                 mul_start_q;
    logic                 div_start_q;

    logic                 accept;
    logic                 is_div;
    logic                 op1_signed;
    logic                 op2_signed;
    rv_pkg::word_t        mul_sel;
    rv_pkg::word_t        div_sel;

    assign accept = start_i && !busy_o && !cancel_i;
    assign is_div = op_i inside {rv_pkg::DIV, rv_pkg::DIVU, rv_pkg::REM, rv_pkg::REMU};

    // signedness per operand from the registered op
    assign op1_signed = op_q inside {rv_pkg::MULH, rv_pkg::MULHSU, rv_pkg::DIV, rv_pkg::REM};
    assign op2_signed = op_q inside {rv_pkg::MULH, rv_pkg::DIV, rv_pkg::REM};

    // low product only for MUL, remainder half for REM and REMU
    assign mul_sel = (op_q == rv_pkg::MUL) ? mul_m.res_lo : mul_m.res_hi;
    assign div_sel = (op_q inside {rv_pkg::REM, rv_pkg::REMU}) ? div_m.res_hi : div_m.res_lo;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q     <= mdu_pkg::IDLE;
            busy_o      <= 1'b0;
            done_o      <= 1'b0;
            result_o    <= '0;
            mul_start_q <= 1'b0;
            div_start_q <= 1'b0;
        end else begin
            mul_start_q <= 1'b0;
            div_start_q <= 1'b0;
            done_o      <= 1'b0;
            case (state_q)
                mdu_pkg::IDLE, mdu_pkg::FINISH: begin
                    if (accept) begin
                        state_q     <= is_div ? mdu_pkg::RUN_DIV : mdu_pkg::RUN_MUL;
                        busy_o      <= 1'b1;
                        mul_start_q <= !is_div;
                        div_start_q <= is_div;
                    end else begin
                        state_q <= mdu_pkg::IDLE;
                    end
                end
                mdu_pkg::RUN_MUL: begin
                    if (cancel_i) begin
                        state_q <= mdu_pkg::IDLE;
                        busy_o  <= 1'b0;
                    end else if (mul_m.stop) begin
                        state_q  <= mdu_pkg::FINISH;
                        busy_o   <= 1'b0;
                        done_o   <= 1'b1;
                        result_o <= mul_sel;
                    end
                end
                mdu_pkg::RUN_DIV: begin
                    if (cancel_i) begin
                        state_q <= mdu_pkg::IDLE;
                        busy_o  <= 1'b0;
                    end else if (div_m.stop) begin
                        state_q  <= mdu_pkg::FINISH;
                        busy_o   <= 1'b0;
                        done_o   <= 1'b1;
                        result_o <= div_sel;
                    end
                end
                default: begin
                    state_q <= mdu_pkg::IDLE;
                    busy_o  <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q  <= op_i;
            op1_q <= op1_i;
            op2_q <= op2_i;
        end
    end

    // both units see the same operands, only start differs
    assign mul_m.start      = mul_start_q;
    assign mul_m.cancel     = cancel_i;
    assign mul_m.op1_signed = op1_signed;
    assign mul_m.op2_signed = op2_signed;
    assign mul_m.op1        = op1_q;
    assign mul_m.op2        = op2_q;

    assign div_m.start      = div_start_q;
    assign div_m.cancel     = cancel_i;
    assign div_m.op1_signed = op1_signed;
    assign div_m.op2_signed = op2_signed;
    assign div_m.op1        = op1_q;
    assign div_m.op2        = op2_q;

    assert property (@(posedge clk) disable iff (reset_i)
        !(mul_m.start && div_m.start));

    assert property (@(posedge clk) disable iff (reset_i)
        done_o |-> (state_q == mdu_pkg::FINISH));

endmodule

//--- mdu_pkg.sv
package mdu_pkg;

    // one shift step per operand bit
    localparam int ITER_CYCLES = rv_pkg::XLEN;

    // accepting edge to done
    // adds the dispatch cycle and the result register cycle
    localparam int LATENCY = ITER_CYCLES + 2;

    // wide enough to hold ITER_CYCLES itself
    localparam int CNT_W = $clog2(ITER_CYCLES) + 1;

    typedef logic [CNT_W-1:0] cnt_t;

    // controller states
    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        RUN_MUL = 2'd1,
        RUN_DIV = 2'd2,
        FINISH  = 2'd3
    } ctrl_state_e;

endpackage

//--- mdu_top.sv
`timescale 1ns/100ps

module mdu_top (
    input  logic            clk,
    input  logic            reset_i,
    input  logic            start_i,
    input  rv_pkg::mdu_op_e op_i,
    input  rv_pkg::word_t   op1_i,
    input  rv_pkg::word_t   op2_i,
    input  logic            cancel_i,
    output logic            busy_o,
    output logic            done_o,
    output rv_pkg::word_t   result_o
);

    // one bus per iterative unit
    iter_if mul_bus ();
    iter_if div_bus ();

    mdu_ctrl u_mdu_ctrl (
        .clk      (clk),
        .reset_i  (reset_i),
        .start_i  (start_i),
        .op_i     (op_i),
        .op1_i    (op1_i),
        .op2_i    (op2_i),
        .cancel_i (cancel_i),
        .busy_o   (busy_o),
        .done_o   (done_o),
        .result_o (result_o),
        .mul_m    (mul_bus.master),
        .div_m    (div_bus.master)
    );

    mul_unit u_mul_unit (
        .clk     (clk),
        .reset_i (reset_i),
        .bus     (mul_bus.unit)
    );

    div_unit u_div_unit (
        .clk     (clk),
        .reset_i (reset_i),
        .bus     (div_bus.unit)
    );

endmodule

//--- mul_unit.sv
`timescale 1ns/100ps

module mul_unit (
    input  logic clk,
    input  logic reset_i,
    iter_if.unit bus
);

    logic           busy_q;
    logic           stop_q;
    mdu_pkg::cnt_t  cnt_q;
    logic           neg_q;
    rv_pkg::dword_t mcand_q;
    rv_pkg::word_t  mplier_q;
    rv_pkg::dword_t acc_q;
    rv_pkg::word_t  res_lo_q;
    rv_pkg::word_t  res_hi_q;

    logic           sign1;
    logic           sign2;
    rv_pkg::word_t  mag1;
    rv_pkg::word_t  mag2;
    rv_pkg::dword_t acc_next;
    rv_pkg::dword_t prod;
    logic           last_step;

    assign sign1 = bus.op1_signed & bus.op1[rv_pkg::XLEN-1];
    assign sign2 = bus.op2_signed & bus.op2[rv_pkg::XLEN-1];
    assign mag1  = sign1 ? -bus.op1 : bus.op1;
    assign mag2  = sign2 ? -bus.op2 : bus.op2;

    // add the shifted multiplicand when the current multiplier bit is set
    assign acc_next  = mplier_q[0] ? acc_q + mcand_q : acc_q;
    assign prod      = neg_q ? -acc_next : acc_next;
    assign last_step = busy_q && (cnt_q == mdu_pkg::cnt_t'(mdu_pkg::ITER_CYCLES - 1));

    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy_q <= 1'b0;
            stop_q <= 1'b0;
            cnt_q  <= '0;
        end else begin
            stop_q <= 1'b0;
            if (bus.cancel) begin
                busy_q <= 1'b0;
            end else if (bus.start) begin
                busy_q <= 1'b1;
                cnt_q  <= '0;
            end else if (busy_q) begin
                cnt_q <= cnt_q + 1'b1;
                if (last_step) begin
                    busy_q <= 1'b0;
                    stop_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus.start) begin
            mcand_q  <= {{rv_pkg::XLEN{1'b0}}, mag1};
            mplier_q <= mag2;
            acc_q    <= '0;
            neg_q    <= sign1 ^ sign2;
        end else if (busy_q && !bus.cancel) begin
            acc_q    <= acc_next;
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
            if (last_step) begin
                res_lo_q <= prod[rv_pkg::XLEN-1:0];
                res_hi_q <= prod[2*rv_pkg::XLEN-1:rv_pkg::XLEN];
            end
        end
    end

    assign bus.stop   = stop_q;
    assign bus.res_lo = res_lo_q;
    assign bus.res_hi = res_hi_q;

    // stop only ends a run that started ITER_CYCLES steps after its capture edge
    assert property (@(posedge clk) disable iff (reset_i)
        $rose(bus.stop) |-> $past(busy_q) && $past(bus.start, mdu_pkg::ITER_CYCLES + 1));

endmodule

//--- rv_pkg.sv
package rv_pkg;

    // base integer register width
    localparam int XLEN = 32;

    // operand and result word
    typedef logic [XLEN-1:0] word_t;

    // full width product of two words
    typedef logic [2*XLEN-1:0] dword_t;

    // M extension operations, encoded as the funct3 field
    typedef enum logic [2:0] {
        MUL    = 3'b000,
        MULH   = 3'b001,
        MULHSU = 3'b010,
        MULHU  = 3'b011,
        DIV    = 3'b100,
        DIVU   = 3'b101,
        REM    = 3'b110,
        REMU   = 3'b111
    } mdu_op_e;

endpackage

//--- tb_mdu.sv
`timescale 1ns/100ps

module tb_mdu;

    // operations issued over all tests: 8 fixed, 200 random, 32 corner, 2 + 3 control
    localparam int NUM_OPS    = 245;
    localparam int MAX_CYCLES = NUM_OPS * (mdu_pkg::LATENCY + 4) * 2 + 20;

    logic            clk;
    logic            reset_i;
    logic            start_i;
    rv_pkg::mdu_op_e op_i;
    rv_pkg::word_t   op1_i;
    rv_pkg::word_t   op2_i;
    logic            cancel_i;
    logic            busy_o;
    logic            done_o;
    rv_pkg::word_t   result_o;

    rv_pkg::word_t   exp_q[$];
    int              accept_q[$];
    int              cycle_cnt = 0;
    int              done_cnt = 0;
    int              err_cnt = 0;
    int              check_cnt = 0;
    int              test_ok = 0;
    int              test_bad = 0;
    int              latency;

    mdu_top DUT (
        .clk      (clk),
        .reset_i  (reset_i),
        .start_i  (start_i),
        .op_i     (op_i),
        .op1_i    (op1_i),
        .op2_i    (op2_i),
        .cancel_i (cancel_i),
        .busy_o   (busy_o),
        .done_o   (done_o),
        .result_o (result_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ISA result of an M extension operation
    function automatic rv_pkg::word_t ref_mdu(input rv_pkg::mdu_op_e op,
                                              input rv_pkg::word_t a, input rv_pkg::word_t b);
        rv_pkg::dword_t                 sa;
        rv_pkg::dword_t                 ua;
        rv_pkg::dword_t                 sb;
        rv_pkg::dword_t                 ub;
        rv_pkg::dword_t                 prod;
        logic                           ovf;
        rv_pkg::word_t                  res;
        logic signed [rv_pkg::XLEN-1:0] sres;
        sa   = {{rv_pkg::XLEN{a[rv_pkg::XLEN-1]}}, a};
        ua   = {{rv_pkg::XLEN{1'b0}}, a};
        sb   = {{rv_pkg::XLEN{b[rv_pkg::XLEN-1]}}, b};
        ub   = {{rv_pkg::XLEN{1'b0}}, b};
        ovf  = (a == {1'b1, {(rv_pkg::XLEN-1){1'b0}}}) && (b == '1);
        prod = '0;
        res  = '0;
        sres = '0;
        case (op)
            rv_pkg::MUL:    prod = ua * ub;
            rv_pkg::MULH:   prod = sa * sb;
            rv_pkg::MULHSU: prod = sa * ub;
            rv_pkg::MULHU:  prod = ua * ub;
            default:        prod = '0;
        endcase
        case (op)
            rv_pkg::MUL:    res = prod[rv_pkg::XLEN-1:0];
            rv_pkg::MULH, rv_pkg::MULHSU, rv_pkg::MULHU:
                            res = prod[2*rv_pkg::XLEN-1:rv_pkg::XLEN];
            rv_pkg::DIV: begin
                if (b == '0) begin
                    res = '1;
                end else if (ovf) begin
                    res = a;
                end else begin
                    sres = $signed(a) / $signed(b);
                    res  = sres;
                end
            end
            rv_pkg::DIVU:   res = (b == '0) ? '1 : a / b;
            rv_pkg::REM: begin
                if (b == '0) begin
                    res = a;
                end else if (ovf) begin
                    res = '0;
                end else begin
                    sres = $signed(a) % $signed(b);
                    res  = sres;
                end
            end
            default:        res = (b == '0) ? a : a % b;
        endcase
        return res;
    endfunction

    task automatic check_result(input string what, input rv_pkg::word_t got,
                                input rv_pkg::word_t exp);
        check_cnt = check_cnt + 1;
        if (got !== exp) begin
            err_cnt = err_cnt + 1;
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        check_cnt = check_cnt + 1;
        if (got !== exp) begin
            err_cnt = err_cnt + 1;
            $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        check_cnt = check_cnt + 1;
        if (got != exp) begin
            err_cnt = err_cnt + 1;
            $display("CHECK FAILED at %0t: done_o came %0d cycles after acceptance, expected %0d",
                     $time, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            test_ok = test_ok + 1;
            $display("test %s: ok", name);
        end else begin
            test_bad = test_bad + 1;
            $display("test %s: %0d errors", name, err_cnt - errs_before);
        end
    endtask

    // one cycle start pulse
    task automatic issue_op(input rv_pkg::mdu_op_e op, input rv_pkg::word_t a,
                            input rv_pkg::word_t b);
        @(posedge clk);
        start_i <= 1'b1;
        op_i    <= op;
        op1_i   <= a;
        op2_i   <= b;
        @(posedge clk);
        start_i <= 1'b0;
    endtask

    task automatic wait_done(input int target);
        while (done_cnt < target) begin
            @(posedge clk);
        end
    endtask

    task automatic run_op(input rv_pkg::mdu_op_e op, input rv_pkg::word_t a,
                          input rv_pkg::word_t b);
        int target;
        target = done_cnt + 1;
        issue_op(op, a, b);
        wait_done(target);
    endtask

    task automatic pick_corner(input int k, output rv_pkg::word_t a, output rv_pkg::word_t b);
        case (k)
            0:       begin a = 32'h1234_5678; b = 32'h0000_0000; end
            1:       begin a = 32'h8000_0000; b = 32'hFFFF_FFFF; end
            2:       begin a = 32'hFFFF_FFFB; b = 32'h0000_0007; end
            default: begin a = 32'h0000_0007; b = 32'hFFFF_FFFB; end
        endcase
    endtask

    // acceptance as the DUT sees it, values before this edge
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: the run was stopped after %0d cycles without finishing",
                     cycle_cnt);
            $display("tests failed");
            $finish;
        end else if (!reset_i) begin
            if (start_i && !busy_o && !cancel_i) begin
                exp_q.push_back(ref_mdu(op_i, op1_i, op2_i));
                accept_q.push_back(cycle_cnt);
            end else if (cancel_i && busy_o && exp_q.size() > 0) begin
                void'(exp_q.pop_front());
                void'(accept_q.pop_front());
            end
        end
    end

    always @(negedge clk) begin
        if (!reset_i && done_o) begin
            if (exp_q.size() == 0) begin
                err_cnt = err_cnt + 1;
                $display("done_o pulsed at %0t with no operation pending", $time);
            end else begin
                check_result("result_o", result_o, exp_q.pop_front());
                latency = cycle_cnt - accept_q.pop_front();
                check_latency(latency, mdu_pkg::LATENCY);
            end
            done_cnt = done_cnt + 1;
        end
    end

    initial begin
        int              errs;
        int              target;
        rv_pkg::word_t   a;
        rv_pkg::word_t   b;
        rv_pkg::mdu_op_e op;
        void'($urandom(64514));
        reset_i  = 1'b1;
        start_i  = 1'b0;
        op_i     = rv_pkg::MUL;
        op1_i    = '0;
        op2_i    = '0;
        cancel_i = 1'b0;
        repeat (10) @(posedge clk);
        reset_i <= 1'b0;

        errs = err_cnt;
        @(negedge clk);
        check_flag("busy_o after reset", busy_o, 1'b0);
        check_flag("done_o after reset", done_o, 1'b0);
        check_result("result_o after reset", result_o, '0);
        for (int i = 0; i < 8; i++) begin
            run_op(rv_pkg::mdu_op_e'(i), 32'h8765_4321, 32'h0000_0123);
        end
        report_test("1 reset and fixed operations", errs);

        errs = err_cnt;
        for (int i = 0; i < 200; i++) begin
            op = rv_pkg::mdu_op_e'($urandom_range(7, 0));
            a  = $urandom;
            // small divisors now and then
            b  = ($urandom_range(3, 0) == 0) ? $urandom_range(15, 0) : $urandom;
            run_op(op, a, b);
        end
        report_test("2 random operations", errs);

        errs = err_cnt;
        for (int i = 0; i < 8; i++) begin
            for (int k = 0; k < 4; k++) begin
                pick_corner(k, a, b);
                run_op(rv_pkg::mdu_op_e'(i), a, b);
            end
        end
        report_test("3 corner operands", errs);

        errs = err_cnt;
        target = done_cnt + 1;
        issue_op(rv_pkg::MULHU, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
        repeat (5) @(posedge clk);
        @(negedge clk);
        check_flag("busy_o during operation", busy_o, 1'b1);
        issue_op(rv_pkg::DIVU, 32'h0000_0064, 32'h0000_0007);
        wait_done(target);
        repeat (mdu_pkg::LATENCY + 4) @(posedge clk);
        check_flag("done_o from ignored start", done_cnt != target, 1'b0);
        report_test("4 start while busy", errs);

        errs = err_cnt;
        target = done_cnt;
        issue_op(rv_pkg::DIV, 32'h7FFF_FFFF, 32'h0000_0003);
        repeat (10) @(posedge clk);
        cancel_i <= 1'b1;
        @(posedge clk);
        cancel_i <= 1'b0;
        @(negedge clk);
        check_flag("busy_o after cancel", busy_o, 1'b0);
        repeat (mdu_pkg::LATENCY) @(posedge clk);
        check_flag("done_o after cancel", done_cnt != target, 1'b0);
        run_op(rv_pkg::REM, 32'hFFFF_FF9C, 32'h0000_0007);
        run_op(rv_pkg::MULH, 32'h8000_0000, 32'h7FFF_FFFF);
        report_test("5 cancel in flight", errs);

        $display("summary: %0d tests, %0d ok, %0d with errors, %0d checks, %0d errors",
                 test_ok + test_bad, test_ok, test_bad, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
